// File: design/pcie_tlp_pkg.sv
package pcie_tlp_pkg;

  // stream width, one dword per beat
  localparam int TLP_DATA_W = 32;
  localparam int TLP_KEEP_W = TLP_DATA_W / 8;

  // traffic class for flow control
  typedef enum logic [1:0] {
    tlp_posted,
    tlp_non_posted,
    tlp_completion
  } tlp_class_e;

  // fmt/type field codes from header byte 0
  localparam logic [4:0] TLP_TYPE_CPL = 5'b01010;
  localparam logic [4:0] TLP_TYPE_MEM = 5'b00000;

  // header dword 0 field positions
  localparam int TLP_TYPE_LSB = 0;
  localparam int TLP_DATA_BIT = 6;
  localparam int TLP_LEN_HI_LSB = 16;
  localparam int TLP_LEN_LO_LSB = 24;

  // credit counter widths
  localparam int FC_HDR_W = 8;
  localparam int FC_DATA_W = 12;

  // one data credit covers 16 bytes
  localparam int FC_DWORDS_PER_CREDIT = 4;

endpackage

// File: design/dll_frame_pkg.sv
package dll_frame_pkg;

  // sequence number width
  localparam int DLL_SEQ_W = 12;

  // framer states
  typedef enum logic [1:0] {
    fr_idle,
    fr_stream,
    fr_crc_lo,
    fr_crc_hi
  } framer_state_e;

  // reflected crc-32 polynomial
  localparam logic [31:0] LCRC_POLY = 32'hEDB88320;

  // seed value, all ones
  localparam logic [31:0] LCRC_INIT = 32'hFFFFFFFF;

endpackage

// File: design/axis_skid_buffer.sv
`timescale 1ns/1ps

module axis_skid_buffer #(
  parameter int WIDTH = 32
) (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic [WIDTH-1:0] s_data_i,
  input  logic             s_valid_i,
  output logic             s_ready_o,
  output logic [WIDTH-1:0] m_data_o,
  output logic             m_valid_o,
  input  logic             m_ready_i
);

  logic [WIDTH-1:0] main_data_r;
  logic [WIDTH-1:0] skid_data_r;
  logic             main_valid_r;
  logic             skid_valid_r;
  logic             ready_r;
  logic             main_valid_n;
  logic             skid_valid_n;
  logic             load_main_in;
  logic             load_main_skid;
  logic             load_skid;
  logic             accept;

  assign accept    = s_valid_i && ready_r;
  assign s_ready_o = ready_r;
  assign m_data_o  = main_data_r;
  assign m_valid_o = main_valid_r;

  always_comb begin
    main_valid_n   = main_valid_r;
    skid_valid_n   = skid_valid_r;
    load_main_in   = 1'b0;
    load_main_skid = 1'b0;
    load_skid      = 1'b0;
    if (!main_valid_r || m_ready_i) begin
      // output slot frees up, skid entry goes first
      if (skid_valid_r) begin
        load_main_skid = 1'b1;
        main_valid_n   = 1'b1;
        skid_valid_n   = 1'b0;
      end else begin
        load_main_in = accept;
        main_valid_n = accept;
      end
    end else if (accept) begin
      load_skid    = 1'b1;
      skid_valid_n = 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      main_valid_r <= 1'b0;
      skid_valid_r <= 1'b0;
      ready_r      <= 1'b0;
    end else begin
      main_valid_r <= main_valid_n;
      skid_valid_r <= skid_valid_n;
      ready_r      <= !skid_valid_n;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_main_skid) begin
      main_data_r <= skid_data_r;
    end else if (load_main_in) begin
      main_data_r <= s_data_i;
    end
    if (load_skid) begin
      skid_data_r <= s_data_i;
    end
  end

endmodule

// File: design/tlp_credit_gate.sv
`timescale 1ns/1ps

module tlp_credit_gate (
  input  logic                                clk_i,
  input  logic                                rst_i,
  input  logic [pcie_tlp_pkg::TLP_DATA_W-1:0] head_data_i,
  input  logic                                tlp_start_i,
  input  logic [pcie_tlp_pkg::FC_HDR_W-1:0]   tx_fc_ph_i,
  input  logic [pcie_tlp_pkg::FC_HDR_W-1:0]   tx_fc_nph_i,
  input  logic [pcie_tlp_pkg::FC_DATA_W-1:0]  tx_fc_pd_i,
  input  logic [pcie_tlp_pkg::FC_DATA_W-1:0]  tx_fc_npd_i,
  output logic                                credit_ok_o
);

  import pcie_tlp_pkg::*;

  tlp_class_e           tlp_class;
  logic [4:0]           hdr_type;
  logic                 has_data;
  logic [9:0]           len_field;
  logic [10:0]          len_dw;
  logic [10:0]          len_credits;
  logic [FC_DATA_W-1:0] data_need;
  logic [FC_HDR_W-1:0]  ph_cons_r;
  logic [FC_HDR_W-1:0]  nph_cons_r;
  logic [FC_DATA_W-1:0] pd_cons_r;
  logic [FC_DATA_W-1:0] npd_cons_r;
  logic [FC_HDR_W-1:0]  ph_room;
  logic [FC_HDR_W-1:0]  nph_room;
  logic [FC_DATA_W-1:0] pd_room;
  logic [FC_DATA_W-1:0] npd_room;
  logic                 p_ok;
  logic                 np_ok;

  assign hdr_type  = head_data_i[TLP_TYPE_LSB +: 5];
  assign has_data  = head_data_i[TLP_DATA_BIT];
  assign len_field = {head_data_i[TLP_LEN_HI_LSB +: 2], head_data_i[TLP_LEN_LO_LSB +: 8]};

  // zero length field encodes 1024 dwords
  assign len_dw      = (len_field == '0) ? 11'd1024 : {1'b0, len_field};
  assign len_credits = (len_dw + 11'(FC_DWORDS_PER_CREDIT - 1)) / 11'(FC_DWORDS_PER_CREDIT);
  assign data_need   = has_data ? FC_DATA_W'(len_credits) : '0;

  always_comb begin
    if (hdr_type == TLP_TYPE_CPL) begin
      tlp_class = tlp_completion;
    end else if (hdr_type == TLP_TYPE_MEM && has_data) begin
      tlp_class = tlp_posted;
    end else if (hdr_type[4:3] == 2'b10) begin
      // messages
      tlp_class = tlp_posted;
    end else begin
      tlp_class = tlp_non_posted;
    end
  end

  // remaining room after this tlp, msb set means over the limit
  assign ph_room  = tx_fc_ph_i - ph_cons_r - FC_HDR_W'(1);
  assign nph_room = tx_fc_nph_i - nph_cons_r - FC_HDR_W'(1);
  assign pd_room  = tx_fc_pd_i - pd_cons_r - data_need;
  assign npd_room = tx_fc_npd_i - npd_cons_r - data_need;

  assign p_ok  = !ph_room[FC_HDR_W-1] && (!has_data || !pd_room[FC_DATA_W-1]);
  assign np_ok = !nph_room[FC_HDR_W-1] && (!has_data || !npd_room[FC_DATA_W-1]);

  always_comb begin
    case (tlp_class)
      tlp_posted:     credit_ok_o = p_ok;
      tlp_non_posted: credit_ok_o = np_ok;
      default:        credit_ok_o = 1'b1;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ph_cons_r  <= '0;
      pd_cons_r  <= '0;
      nph_cons_r <= '0;
      npd_cons_r <= '0;
    end else if (tlp_start_i) begin
      case (tlp_class)
        tlp_posted: begin
          ph_cons_r <= ph_cons_r + FC_HDR_W'(1);
          pd_cons_r <= pd_cons_r + data_need;
        end
        tlp_non_posted: begin
          nph_cons_r <= nph_cons_r + FC_HDR_W'(1);
          npd_cons_r <= npd_cons_r + data_need;
        end
        default: begin
        end
      endcase
    end
  end

endmodule

// File: design/lcrc_engine.sv
`timescale 1ns/1ps

module lcrc_engine (
  input  logic [31:0]                         crc_i,
  input  logic [pcie_tlp_pkg::TLP_DATA_W-1:0] data_i,
  input  logic                                two_bytes_i,
  output logic [31:0]                         crc_o
);

  import dll_frame_pkg::*;

  logic [31:0] crc_acc;

  // one byte, lsb first
  function automatic logic [31:0] crc_byte(input logic [31:0] crc, input logic [7:0] data);
    logic [31:0] c;
    c = crc ^ {24'h0, data};
    for (int k = 0; k < 8; k++) begin
      if (c[0]) begin
        c = (c >> 1) ^ LCRC_POLY;
      end else begin
        c = c >> 1;
      end
    end
    return c;
  endfunction

  always_comb begin
    crc_acc = crc_i;
    crc_acc = crc_byte(crc_acc, data_i[7:0]);
    crc_acc = crc_byte(crc_acc, data_i[15:8]);
    // upper half only on full beats
    if (!two_bytes_i) begin
      crc_acc = crc_byte(crc_acc, data_i[23:16]);
      crc_acc = crc_byte(crc_acc, data_i[31:24]);
    end
    crc_o = crc_acc;
  end

endmodule

// File: design/dll_tx_framer.sv
`timescale 1ns/1ps

module dll_tx_framer (
  input  logic                                clk_i,
  input  logic                                rst_i,
  input  logic [pcie_tlp_pkg::TLP_DATA_W-1:0] head_data_i,
  input  logic                                head_last_i,
  input  logic                                head_valid_i,
  output logic                                head_ready_o,
  input  logic                                credit_ok_i,
  output logic                                tlp_start_o,
  output logic [pcie_tlp_pkg::TLP_DATA_W-1:0] fr_data_o,
  output logic [pcie_tlp_pkg::TLP_KEEP_W-1:0] fr_keep_o,
  output logic                                fr_last_o,
  output logic                                fr_valid_o,
  input  logic                                fr_ready_i,
  output logic [dll_frame_pkg::DLL_SEQ_W-1:0] seq_num_o,
  output logic                                dllp_valid_o
);

  import pcie_tlp_pkg::*;
  import dll_frame_pkg::*;

  framer_state_e         state_r;
  logic [15:0]           hold_r;
  logic [31:0]           crc_r;
  logic [DLL_SEQ_W-1:0]  seq_r;
  logic [TLP_DATA_W-1:0] beat_data;
  logic [31:0]           crc_seed;
  logic [31:0]           crc_next;
  logic [31:0]           crc_fin;
  logic                  beat_fire;

  assign seq_num_o = seq_r;
  assign beat_fire = fr_valid_o && fr_ready_i;

  // sequence bytes lead the first beat, later beats are shifted by two bytes
  always_comb begin
    if (state_r == fr_idle) begin
      beat_data = {head_data_i[15:0], seq_r[7:0], 4'h0, seq_r[11:8]};
    end else begin
      beat_data = {head_data_i[15:0], hold_r};
    end
  end

  assign crc_seed = (state_r == fr_idle) ? LCRC_INIT : crc_r;
  assign crc_fin  = ~crc_next;

  // in fr_crc_lo only the held bytes are new
  lcrc_engine u_lcrc (
    .crc_i       (crc_seed),
    .data_i      (beat_data),
    .two_bytes_i (state_r == fr_crc_lo),
    .crc_o       (crc_next)
  );

  always_comb begin
    head_ready_o = 1'b0;
    tlp_start_o  = 1'b0;
    fr_valid_o   = 1'b0;
    fr_data_o    = beat_data;
    fr_keep_o    = '1;
    fr_last_o    = 1'b0;
    dllp_valid_o = 1'b0;
    case (state_r)
      fr_idle: begin
        head_ready_o = credit_ok_i && fr_ready_i;
        fr_valid_o   = head_valid_i && credit_ok_i;
        tlp_start_o  = head_valid_i && credit_ok_i && fr_ready_i;
      end
      fr_stream: begin
        head_ready_o = fr_ready_i;
        fr_valid_o   = head_valid_i;
      end
      fr_crc_lo: begin
        fr_valid_o = 1'b1;
        fr_data_o  = {crc_fin[15:0], hold_r};
      end
      fr_crc_hi: begin
        fr_valid_o   = 1'b1;
        fr_data_o    = {16'h0, crc_r[31:16]};
        fr_keep_o    = 4'b0011;
        fr_last_o    = 1'b1;
        dllp_valid_o = fr_ready_i;
      end
      default: begin
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_r <= fr_idle;
      seq_r   <= '0;
    end else if (beat_fire) begin
      case (state_r)
        fr_idle: begin
          state_r <= head_last_i ? fr_crc_lo : fr_stream;
        end
        fr_stream: begin
          if (head_last_i) begin
            state_r <= fr_crc_lo;
          end
        end
        fr_crc_lo: begin
          state_r <= fr_crc_hi;
        end
        fr_crc_hi: begin
          state_r <= fr_idle;
          seq_r   <= seq_r + 1'b1;
        end
        default: begin
          state_r <= fr_idle;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (beat_fire) begin
      case (state_r)
        fr_idle, fr_stream: begin
          hold_r <= head_data_i[31:16];
          crc_r  <= crc_next;
        end
        // keep the inverted value for the upper crc bytes
        fr_crc_lo: begin
          crc_r <= crc_fin;
        end
        default: begin
        end
      endcase
    end
  end

endmodule

// File: design/dll_tx_top.sv
`timescale 1ns/1ps

module dll_tx_top (
  input  logic                                clk_i,
  input  logic                                rst_i,
  input  logic [pcie_tlp_pkg::TLP_DATA_W-1:0] s_axis_tdata_i,
  input  logic                                s_axis_tvalid_i,
  input  logic                                s_axis_tlast_i,
  output logic                                s_axis_tready_o,
  output logic [pcie_tlp_pkg::TLP_DATA_W-1:0] m_axis_tdata_o,
  output logic [pcie_tlp_pkg::TLP_KEEP_W-1:0] m_axis_tkeep_o,
  output logic                                m_axis_tvalid_o,
  output logic                                m_axis_tlast_o,
  input  logic                                m_axis_tready_i,
  output logic [dll_frame_pkg::DLL_SEQ_W-1:0] seq_num_o,
  output logic                                dllp_valid_o,
  input  logic [pcie_tlp_pkg::FC_HDR_W-1:0]   tx_fc_ph_i,
  input  logic [pcie_tlp_pkg::FC_DATA_W-1:0]  tx_fc_pd_i,
  input  logic [pcie_tlp_pkg::FC_HDR_W-1:0]   tx_fc_nph_i,
  input  logic [pcie_tlp_pkg::FC_DATA_W-1:0]  tx_fc_npd_i
);

  import pcie_tlp_pkg::*;

  logic [TLP_DATA_W-1:0] head_data;
  logic                  head_last;
  logic                  head_valid;
  logic                  head_ready;
  logic                  credit_ok;
  logic                  tlp_start;
  logic [TLP_DATA_W-1:0] fr_data;
  logic [TLP_KEEP_W-1:0] fr_keep;
  logic                  fr_last;
  logic                  fr_valid;
  logic                  fr_ready;

  // data plus last
  axis_skid_buffer #(
    .WIDTH (TLP_DATA_W + 1)
  ) u_ingress (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .s_data_i  ({s_axis_tlast_i, s_axis_tdata_i}),
    .s_valid_i (s_axis_tvalid_i),
    .s_ready_o (s_axis_tready_o),
    .m_data_o  ({head_last, head_data}),
    .m_valid_o (head_valid),
    .m_ready_i (head_ready)
  );

  tlp_credit_gate u_credit (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .head_data_i (head_data),
    .tlp_start_i (tlp_start),
    .tx_fc_ph_i  (tx_fc_ph_i),
    .tx_fc_nph_i (tx_fc_nph_i),
    .tx_fc_pd_i  (tx_fc_pd_i),
    .tx_fc_npd_i (tx_fc_npd_i),
    .credit_ok_o (credit_ok)
  );

  dll_tx_framer u_framer (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .head_data_i  (head_data),
    .head_last_i  (head_last),
    .head_valid_i (head_valid),
    .head_ready_o (head_ready),
    .credit_ok_i  (credit_ok),
    .tlp_start_o  (tlp_start),
    .fr_data_o    (fr_data),
    .fr_keep_o    (fr_keep),
    .fr_last_o    (fr_last),
    .fr_valid_o   (fr_valid),
    .fr_ready_i   (fr_ready),
    .seq_num_o    (seq_num_o),
    .dllp_valid_o (dllp_valid_o)
  );

  // data, keep and last
  axis_skid_buffer #(
    .WIDTH (TLP_DATA_W + TLP_KEEP_W + 1)
  ) u_egress (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .s_data_i  ({fr_last, fr_keep, fr_data}),
    .s_valid_i (fr_valid),
    .s_ready_o (fr_ready),
    .m_data_o  ({m_axis_tlast_o, m_axis_tkeep_o, m_axis_tdata_o}),
    .m_valid_o (m_axis_tvalid_o),
    .m_ready_i (m_axis_tready_i)
  );

endmodule

// File: verification/dll_tx_clkgen.sv
`timescale 1ns/1ps

module dll_tx_clkgen (
  output logic clk_o,
  output logic rst_o
);

  // 40 ns period
  initial begin
    clk_o = 1'b0;
    forever begin
      #20 clk_o = ~clk_o;
    end
  end

  initial begin
    rst_o = 1'b1;
    repeat (10) @(posedge clk_o);
    rst_o <= 1'b0;
  end

endmodule

// File: verification/dll_tx_checker.sv
`timescale 1ns/1ps

module dll_tx_checker (
  input logic                                clk_i,
  input logic                                rst_i,
  input logic [pcie_tlp_pkg::TLP_DATA_W-1:0] m_axis_tdata_o,
  input logic [pcie_tlp_pkg::TLP_KEEP_W-1:0] m_axis_tkeep_o,
  input logic                                m_axis_tvalid_o,
  input logic                                m_axis_tlast_o,
  input logic                                m_axis_tready_i,
  input logic [dll_frame_pkg::DLL_SEQ_W-1:0] seq_num_o,
  input logic                                dllp_valid_o
);

  // stalled beat must hold still
  stable_on_stall: assert property (@(posedge clk_i) disable iff (rst_i)
    m_axis_tvalid_o && !m_axis_tready_i |=>
      $stable({m_axis_tlast_o, m_axis_tkeep_o, m_axis_tdata_o}) && m_axis_tvalid_o)
    else $error("egress beat changed while stalled");

  valid_low_after_reset: assert property (@(posedge clk_i) $fell(rst_i) |-> !m_axis_tvalid_o)
    else $error("m_axis_tvalid_o high right after reset");

  // seq moves only after a finished frame
  seq_after_dllp: assert property (@(posedge clk_i) disable iff (rst_i)
    !$stable(seq_num_o) |-> $past(dllp_valid_o))
    else $error("seq_num_o changed without dllp_valid_o");

endmodule

bind dll_tx_top dll_tx_checker u_checker (
  .clk_i           (clk_i),
  .rst_i           (rst_i),
  .m_axis_tdata_o  (m_axis_tdata_o),
  .m_axis_tkeep_o  (m_axis_tkeep_o),
  .m_axis_tvalid_o (m_axis_tvalid_o),
  .m_axis_tlast_o  (m_axis_tlast_o),
  .m_axis_tready_i (m_axis_tready_i),
  .seq_num_o       (seq_num_o),
  .dllp_valid_o    (dllp_valid_o)
);

// File: verification/dll_tx_tb.sv
`timescale 1ns/1ps

module dll_tx_tb;

  import pcie_tlp_pkg::*;
  import dll_frame_pkg::*;

  typedef logic [7:0] byte_q_t[$];
  typedef logic [TLP_DATA_W-1:0] word_q_t[$];

  logic                  clk;
  logic                  rst;
  logic [TLP_DATA_W-1:0] s_tdata;
  logic                  s_tvalid;
  logic                  s_tlast;
  logic                  s_tready;
  logic [TLP_DATA_W-1:0] m_tdata;
  logic [TLP_KEEP_W-1:0] m_tkeep;
  logic                  m_tvalid;
  logic                  m_tlast;
  logic                  m_tready;
  logic [DLL_SEQ_W-1:0]  seq_num;
  logic                  dllp_valid;
  logic [FC_HDR_W-1:0]   fc_ph;
  logic [FC_DATA_W-1:0]  fc_pd;
  logic [FC_HDR_W-1:0]   fc_nph;
  logic [FC_DATA_W-1:0]  fc_npd;

  logic [TLP_DATA_W:0]   in_q[$];
  logic [TLP_DATA_W-1:0] exp_data_q[$];
  logic [TLP_KEEP_W-1:0] exp_keep_q[$];
  logic                  exp_last_q[$];
  logic [DLL_SEQ_W-1:0]  exp_seq;
  int                    frames_out;
  int                    dllp_seen;
  int                    ph_used;
  int                    pd_used;
  int                    nph_used;
  bit                    rand_ready;

  dll_tx_clkgen u_clkgen (.clk_o(clk), .rst_o(rst));

  dll_tx_top dut_i (
    .clk_i           (clk),
    .rst_i           (rst),
    .s_axis_tdata_i  (s_tdata),
    .s_axis_tvalid_i (s_tvalid),
    .s_axis_tlast_i  (s_tlast),
    .s_axis_tready_o (s_tready),
    .m_axis_tdata_o  (m_tdata),
    .m_axis_tkeep_o  (m_tkeep),
    .m_axis_tvalid_o (m_tvalid),
    .m_axis_tlast_o  (m_tlast),
    .m_axis_tready_i (m_tready),
    .seq_num_o       (seq_num),
    .dllp_valid_o    (dllp_valid),
    .tx_fc_ph_i      (fc_ph),
    .tx_fc_pd_i      (fc_pd),
    .tx_fc_nph_i     (fc_nph),
    .tx_fc_npd_i     (fc_npd)
  );

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("CHECKS FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check_data(input string name, input logic [TLP_DATA_W-1:0] got,
                            input logic [TLP_DATA_W-1:0] exp);
    if (got !== exp) begin
      stop_run($sformatf("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_keep(input string name, input logic [TLP_KEEP_W-1:0] got,
                            input logic [TLP_KEEP_W-1:0] exp);
    if (got !== exp) begin
      stop_run($sformatf("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp));
    end
  endtask

  task automatic check_seq(input string name, input logic [DLL_SEQ_W-1:0] got,
                           input logic [DLL_SEQ_W-1:0] exp);
    if (got !== exp) begin
      stop_run($sformatf("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp));
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      stop_run($sformatf("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      stop_run($sformatf("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp));
    end
  endtask

  // reflected crc-32 with final inversion
  function automatic logic [31:0] ref_lcrc(input byte_q_t b);
    logic [31:0] c;
    c = 32'hFFFFFFFF;
    foreach (b[i]) begin
      c = c ^ {24'h0, b[i]};
      repeat (8) begin
        c = c[0] ? ((c >> 1) ^ 32'hEDB88320) : (c >> 1);
      end
    end
    return ~c;
  endfunction

  // seq bytes, tlp bytes and lcrc bytes cut into dwords
  function automatic void build_frame(input word_q_t words, input logic [11:0] seq);
    byte_q_t             b;
    logic [31:0]         crc;
    logic [31:0]         beat;
    logic [3:0]          keep;
    int                  i;
    b.push_back({4'h0, seq[11:8]});
    b.push_back(seq[7:0]);
    foreach (words[w]) begin
      for (int k = 0; k < 4; k++) begin
        b.push_back(words[w][8*k +: 8]);
      end
    end
    crc = ref_lcrc(b);
    for (int k = 0; k < 4; k++) begin
      b.push_back(crc[8*k +: 8]);
    end
    i = 0;
    while (i < b.size()) begin
      beat = '0;
      keep = '0;
      for (int k = 0; k < 4; k++) begin
        if (i + k < b.size()) begin
          beat[8*k +: 8] = b[i+k];
          keep[k] = 1'b1;
        end
      end
      exp_data_q.push_back(beat);
      exp_keep_q.push_back(keep);
      exp_last_q.push_back(i + 4 >= b.size());
      i += 4;
    end
  endfunction

  task automatic send_tlp(input logic [7:0] fmt_type, input int len);
    word_q_t words;
    logic    has_data;
    has_data = fmt_type[6];
    words.push_back({len[7:0], 6'h0, len[9:8], 8'h00, fmt_type});
    words.push_back($urandom);
    words.push_back($urandom);
    if (has_data) begin
      repeat (len) words.push_back($urandom);
    end
    foreach (words[i]) begin
      in_q.push_back({i == words.size() - 1, words[i]});
    end
    build_frame(words, exp_seq);
    exp_seq++;
    if (fmt_type[4:0] == 5'b01010) begin
      // completions carry no credit
    end else if ((fmt_type[4:0] == 5'b00000 && has_data) || fmt_type[4:3] == 2'b10) begin
      ph_used++;
      pd_used += has_data ? (len + 3) / 4 : 0;
    end else begin
      nph_used++;
    end
  endtask

  task automatic wait_drained(input int limit);
    int n;
    n = 0;
    while (in_q.size() != 0 || exp_data_q.size() != 0) begin
      @(posedge clk);
      n++;
      if (n > limit) stop_run("timeout waiting for expected frames to leave the DUT");
    end
  endtask

  task automatic wait_frames(input int target);
    int n;
    n = 0;
    while (frames_out < target) begin
      @(posedge clk);
      n++;
      if (n > 2000) stop_run("timeout waiting for a frame on the output");
    end
  endtask

  task automatic test_reset();
    int n;
    check_flag("m_axis_tvalid_o", m_tvalid, 1'b0);
    check_flag("dllp_valid_o", dllp_valid, 1'b0);
    check_seq("seq_num_o", seq_num, '0);
    n = 0;
    while (s_tready !== 1'b1) begin
      @(posedge clk);
      n++;
      if (n > 20) stop_run("s_axis_tready_o never rose after reset");
    end
  endtask

  task automatic test_frame();
    int f0;
    int d0;
    f0 = frames_out;
    d0 = dllp_seen;
    send_tlp(8'h40, 4);
    wait_drained(500);
    @(posedge clk);
    check_count("frames", frames_out, f0 + 1);
    check_count("dllp pulses", dllp_seen, d0 + 1);
    check_seq("seq_num_o", seq_num, exp_seq);
  endtask

  task automatic test_sequence();
    int f0;
    int d0;
    f0 = frames_out;
    d0 = dllp_seen;
    send_tlp(8'h40, 2);
    send_tlp(8'h00, 1);
    send_tlp(8'h30, 1);
    send_tlp(8'h0A, 1);
    send_tlp(8'h4A, 3);
    wait_drained(1000);
    @(posedge clk);
    check_seq("seq_num_o", seq_num, exp_seq);
    check_count("frames", frames_out, f0 + 5);
    check_count("dllp pulses", dllp_seen, d0 + 5);
  endtask

  task automatic test_backpressure();
    rand_ready = 1'b1;
    repeat (12) begin
      send_tlp(($urandom % 2) ? 8'h40 : 8'h00, 1 + $urandom % 8);
    end
    wait_drained(5000);
    rand_ready = 1'b0;
  endtask

  task automatic test_posted_credit();
    int f0;
    f0 = frames_out;
    @(posedge clk);
    fc_ph <= FC_HDR_W'(ph_used + 2);
    fc_pd <= FC_DATA_W'(pd_used + 2);
    @(posedge clk);
    send_tlp(8'h40, 4);
    send_tlp(8'h40, 4);
    wait_frames(f0 + 2);
    send_tlp(8'h0A, 1);
    wait_frames(f0 + 3);
    send_tlp(8'h40, 4);
    repeat (200) @(posedge clk);
    check_count("frames while posted credit exhausted", frames_out, f0 + 3);
    fc_ph <= FC_HDR_W'(ph_used + 100);
    fc_pd <= FC_DATA_W'(pd_used + 1000);
    wait_drained(1000);
    check_count("frames", frames_out, f0 + 4);
  endtask

  task automatic test_np_credit();
    int f0;
    f0 = frames_out;
    @(posedge clk);
    fc_nph <= FC_HDR_W'(nph_used);
    @(posedge clk);
    send_tlp(8'h40, 1);
    wait_frames(f0 + 1);
    send_tlp(8'h00, 2);
    repeat (100) @(posedge clk);
    check_count("frames while non-posted credit exhausted", frames_out, f0 + 1);
    fc_nph <= FC_HDR_W'(nph_used + 100);
    wait_drained(1000);
    check_count("frames", frames_out, f0 + 2);
  endtask

  // input stream driver
  always @(posedge clk) begin
    logic [TLP_DATA_W:0] w;
    if (rst) begin
      s_tvalid <= 1'b0;
    end else if (!s_tvalid || s_tready) begin
      if (in_q.size() > 0) begin
        w = in_q.pop_front();
        s_tdata  <= w[TLP_DATA_W-1:0];
        s_tlast  <= w[TLP_DATA_W];
        s_tvalid <= 1'b1;
      end else begin
        s_tvalid <= 1'b0;
      end
    end
  end

  always @(posedge clk) begin
    m_tready <= rand_ready ? (($urandom % 4) != 0) : 1'b1;
  end

  // output monitor
  always @(posedge clk) begin
    if (!rst) begin
      if (dllp_valid) dllp_seen++;
      if (m_tvalid && m_tready) begin
        if (exp_data_q.size() == 0) begin
          stop_run("output beat arrived with no frame expected");
        end else begin
          check_data("m_axis_tdata_o", m_tdata, exp_data_q.pop_front());
          check_keep("m_axis_tkeep_o", m_tkeep, exp_keep_q.pop_front());
          check_flag("m_axis_tlast_o", m_tlast, exp_last_q.pop_front());
          if (m_tlast) frames_out++;
        end
      end
    end
  end

  initial begin
    int n;
    void'($urandom(58438));
    s_tdata    = '0;
    s_tvalid   = 1'b0;
    s_tlast    = 1'b0;
    m_tready   = 1'b1;
    fc_ph      = 8'd100;
    fc_pd      = 12'd1000;
    fc_nph     = 8'd100;
    fc_npd     = 12'd1000;
    exp_seq    = '0;
    frames_out = 0;
    dllp_seen  = 0;
    ph_used    = 0;
    pd_used    = 0;
    nph_used   = 0;
    rand_ready = 1'b0;
    n = 0;
    while (rst !== 1'b0) begin
      @(posedge clk);
      n++;
      if (n > 50) stop_run("reset never released");
    end
    test_reset();
    test_frame();
    test_sequence();
    test_backpressure();
    test_posted_credit();
    test_np_credit();
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

// File: build.f
design/pcie_tlp_pkg.sv
design/dll_frame_pkg.sv
design/axis_skid_buffer.sv
design/tlp_credit_gate.sv
design/lcrc_engine.sv
design/dll_tx_framer.sv
design/dll_tx_top.sv
verification/dll_tx_clkgen.sv
verification/dll_tx_checker.sv
verification/dll_tx_tb.sv

// File: Makefile
OBJ_DIR = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module dll_tx_tb \
		-Mdir $(OBJ_DIR) -f build.f

run: compile
	./$(OBJ_DIR)/Vdll_tx_tb

clean:
	rm -rf $(OBJ_DIR)
